// File: run_sim.sh
#!/bin/sh
# Build and run the ESDI command channel testbench with Verilator
set -e

verilator --binary --timing --assert -j 0 --top-module esdi_cmd_tb -f vlog.f -o esdi_cmd_sim

# Simulator status is ignored here, the log decides
./obj_dir/esdi_cmd_sim | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"

// File: source/esdi_bit_rx.sv
// Start cycle counts as bit cycle 0 so back-to-back words keep their phase; mid-bit sample only
`timescale 1ns/1ns

module esdi_bit_rx #(
    parameter int BIT_PERIOD = 200
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               rx_start,
    input  logic               rx_line,
    output logic               rx_done,
    output esdi_pkg::esdi_word_t rx_word,
    output logic               rx_parity_ok
);

    import esdi_pkg::*;

    localparam int TW = $clog2(BIT_PERIOD);

    esdi_frame_t   shift;
    logic [TW-1:0] bit_timer;
    logic [4:0]    bit_count;
    logic          active;

    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            rx_done   <= 1'b0;
            bit_timer <= '0;
            bit_count <= '0;
        end else begin
            rx_done <= 1'b0;
            if (rx_start) begin
                // The start cycle itself was cycle 0
                active    <= 1'b1;
                bit_timer <= TW'(1);
                bit_count <= '0;
            end else if (active) begin
                if (bit_timer == TW'(BIT_PERIOD - 1)) begin
                    bit_timer <= '0;
                    bit_count <= bit_count + 5'd1;
                    // Done lands on cycle 0 of the next frame
                    if (bit_count == 5'd16) begin
                        active  <= 1'b0;
                        rx_done <= 1'b1;
                    end
                end else begin
                    bit_timer <= bit_timer + TW'(1);
                end
            end
        end
    end

    // Mid-bit sampling into the frame register
    always_ff @(posedge clk) begin
        if (active && bit_timer == TW'(BIT_PERIOD / 2)) begin
            shift <= {shift[15:0], rx_line};
        end
    end

    assign rx_word      = shift[16:1];
    assign rx_parity_ok = (esdi_parity(shift[16:1]) == shift[0]);

    // Restart only between frames
    a_no_start_mid_frame: assert property (
        @(posedge clk) disable iff (reset) rx_start |-> !active
    );

endmodule

// File: source/esdi_bit_tx.sv
// One 17-bit frame per tx_load, MSB first; line reads low whenever no frame is shifting
`timescale 1ns/1ns

module esdi_bit_tx #(
    parameter int BIT_PERIOD = 200
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                tx_load,
    input  esdi_pkg::esdi_frame_t tx_frame,
    output logic                cmd_data_out,
    output logic                tx_done
);

    import esdi_pkg::*;

    localparam int TW = $clog2(BIT_PERIOD);

    esdi_frame_t   shift;
    logic [TW-1:0] bit_timer;
    logic [4:0]    bit_count;
    logic          active;

    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            tx_done   <= 1'b0;
            bit_timer <= '0;
            bit_count <= '0;
        end else begin
            tx_done <= 1'b0;
            if (tx_load) begin
                active    <= 1'b1;
                bit_timer <= '0;
                bit_count <= '0;
            end else if (active) begin
                if (bit_timer == TW'(BIT_PERIOD - 1)) begin
                    // End of one bit period
                    bit_timer <= '0;
                    bit_count <= bit_count + 5'd1;
                    if (bit_count == 5'd16) begin
                        active  <= 1'b0;
                        tx_done <= 1'b1;
                    end
                end else begin
                    bit_timer <= bit_timer + TW'(1);
                end
            end
        end
    end

    // Payload shifter
    always_ff @(posedge clk) begin
        if (tx_load) begin
            shift <= tx_frame;
        end else if (active && bit_timer == TW'(BIT_PERIOD - 1)) begin
            shift <= {shift[15:0], 1'b0};
        end
    end

    assign cmd_data_out = active & shift[16];

    // Sequencer must wait for tx_done before the next frame
    a_no_load_while_busy: assert property (
        @(posedge clk) disable iff (reset) tx_load |-> !active
    );

endmodule

// File: source/esdi_cmd.sv
// ESDI controller command channel; BIT_PERIOD must be at least 2 and the drive sends all words
`timescale 1ns/1ns

module esdi_cmd #(
    parameter int BIT_PERIOD  = 200,
    parameter int ACK_TIMEOUT = 512
) (
    input  logic                      clk,
    input  logic                      reset,
    // Host side
    input  logic                      cmd_enable,
    input  logic                      cmd_start,
    input  esdi_pkg::cmd_request_t    request,
    output logic                      cmd_busy,
    output logic                      cmd_done,
    output logic                      cmd_error,
    output esdi_pkg::esdi_word_t      status_word,
    output logic                      status_valid,
    output esdi_pkg::drive_geometry_t geometry,
    output logic                      config_valid,
    output logic                      attention_pending,
    // Drive cable
    output logic                      cmd_data_out,
    output logic                      cmd_data_oe,
    output logic                      transfer_req,
    input  logic                      status_data_in,
    input  logic                      transfer_ack,
    input  logic                      attention
);

    import esdi_pkg::*;

    // --------------------------------------------------
    // Internal links
    // --------------------------------------------------
    logic        ack_pulse;
    logic        rx_line;
    logic        tx_load;
    logic        tx_done;
    esdi_frame_t tx_frame;
    logic        rx_start;
    logic        rx_done;
    logic        rx_parity_ok;
    esdi_word_t  rx_word;
    logic        cfg_clear;
    logic        cfg_store;
    logic        cfg_finish;

    esdi_line_inputs u_line_inputs (
        .clk(clk), .reset(reset), .transfer_ack(transfer_ack), .attention(attention),
        .status_data_in(status_data_in), .ack_pulse(ack_pulse), .rx_line(rx_line),
        .attention_pending(attention_pending)
    );

    esdi_bit_tx #(.BIT_PERIOD(BIT_PERIOD)) u_bit_tx (
        .clk(clk), .reset(reset), .tx_load(tx_load), .tx_frame(tx_frame),
        .cmd_data_out(cmd_data_out), .tx_done(tx_done)
    );

    esdi_bit_rx #(.BIT_PERIOD(BIT_PERIOD)) u_bit_rx (
        .clk(clk), .reset(reset), .rx_start(rx_start), .rx_line(rx_line),
        .rx_done(rx_done), .rx_word(rx_word), .rx_parity_ok(rx_parity_ok)
    );

    esdi_cmd_seq #(.ACK_TIMEOUT(ACK_TIMEOUT)) u_cmd_seq (
        .clk(clk), .reset(reset), .cmd_enable(cmd_enable), .cmd_start(cmd_start),
        .request(request), .ack_pulse(ack_pulse), .tx_done(tx_done), .rx_done(rx_done),
        .rx_word(rx_word), .rx_parity_ok(rx_parity_ok), .tx_load(tx_load),
        .tx_frame(tx_frame), .rx_start(rx_start), .cfg_clear(cfg_clear),
        .cfg_store(cfg_store), .cfg_finish(cfg_finish), .cmd_data_oe(cmd_data_oe),
        .transfer_req(transfer_req), .cmd_busy(cmd_busy), .cmd_done(cmd_done),
        .cmd_error(cmd_error), .status_word(status_word), .status_valid(status_valid)
    );

    esdi_geometry u_geometry (
        .clk(clk), .reset(reset), .cfg_clear(cfg_clear), .cfg_store(cfg_store),
        .cfg_finish(cfg_finish), .rx_word(rx_word), .geometry(geometry),
        .config_valid(config_valid)
    );

endmodule

// File: source/esdi_cmd_seq.sv
// One command in flight; starts are dropped while busy and the timeout covers each ack wait
`timescale 1ns/1ns

module esdi_cmd_seq #(
    parameter int ACK_TIMEOUT = 512
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_enable,
    input  logic                  cmd_start,
    input  esdi_pkg::cmd_request_t request,
    input  logic                  ack_pulse,
    input  logic                  tx_done,
    input  logic                  rx_done,
    input  esdi_pkg::esdi_word_t  rx_word,
    input  logic                  rx_parity_ok,
    output logic                  tx_load,
    output esdi_pkg::esdi_frame_t tx_frame,
    output logic                  rx_start,
    output logic                  cfg_clear,
    output logic                  cfg_store,
    output logic                  cfg_finish,
    output logic                  cmd_data_oe,
    output logic                  transfer_req,
    output logic                  cmd_busy,
    output logic                  cmd_done,
    output logic                  cmd_error,
    output esdi_pkg::esdi_word_t  status_word,
    output logic                  status_valid
);

    import esdi_pkg::*;

    localparam int AW = $clog2(ACK_TIMEOUT + 1);

    typedef enum logic [2:0] {
        S_IDLE, S_SEND, S_WAIT_ACK, S_RECEIVE, S_DONE, S_ERROR
    } seq_state_t;

    seq_state_t    state;
    cmd_request_t  req;
    logic [AW-1:0] ack_timer;
    logic [2:0]    word_cnt;
    logic          param_sent;
    logic          accept;
    logic          is_config;
    logic          need_param;
    logic          last_word;
    esdi_word_t    header;

    assign accept     = (state == S_IDLE) && cmd_start && cmd_enable;
    assign is_config  = (req.opcode == OP_GET_DEV_CONFIG);
    // SEEK carries a cylinder word after the header
    assign need_param = (req.opcode == OP_SEEK) && !param_sent;
    assign last_word  = (word_cnt == (is_config ? 3'(CONFIG_WORDS - 1) : 3'd0));
    // Bits 15-14 and 12-8 stay zero
    assign header     = {2'b00, request.drive, 5'b00000, request.opcode};

    // --------------------------------------------------
    // Receiver and configuration strobes
    // --------------------------------------------------
    assign rx_start   = ((state == S_WAIT_ACK) && ack_pulse && !need_param) ||
                        ((state == S_RECEIVE) && rx_done && !last_word);
    assign cfg_clear  = accept;
    assign cfg_store  = (state == S_RECEIVE) && rx_done && is_config;
    assign cfg_finish = (state == S_DONE) && is_config;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_IDLE;
            tx_load      <= 1'b0;
            cmd_data_oe  <= 1'b0;
            transfer_req <= 1'b0;
            cmd_busy     <= 1'b0;
            cmd_done     <= 1'b0;
            cmd_error    <= 1'b0;
            status_valid <= 1'b0;
            ack_timer    <= '0;
            word_cnt     <= '0;
            param_sent   <= 1'b0;
        end else begin
            tx_load      <= 1'b0;
            cmd_done     <= 1'b0;
            status_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state        <= S_SEND;
                        tx_load      <= 1'b1;
                        cmd_data_oe  <= 1'b1;
                        transfer_req <= 1'b1;
                        cmd_busy     <= 1'b1;
                        cmd_error    <= 1'b0;
                        param_sent   <= 1'b0;
                        word_cnt     <= '0;
                    end
                end
                S_SEND: begin
                    if (tx_done) begin
                        // Release the line while the drive answers
                        state        <= S_WAIT_ACK;
                        cmd_data_oe  <= 1'b0;
                        transfer_req <= 1'b0;
                        ack_timer    <= '0;
                    end
                end
                S_WAIT_ACK: begin
                    ack_timer <= ack_timer + AW'(1);
                    if (ack_pulse) begin
                        if (need_param) begin
                            state        <= S_SEND;
                            tx_load      <= 1'b1;
                            cmd_data_oe  <= 1'b1;
                            transfer_req <= 1'b1;
                            param_sent   <= 1'b1;
                        end else begin
                            state <= S_RECEIVE;
                        end
                    end else if (ack_timer == AW'(ACK_TIMEOUT - 1)) begin
                        state <= S_ERROR;
                    end
                end
                S_RECEIVE: begin
                    if (rx_done) begin
                        word_cnt <= word_cnt + 3'd1;
                        // Bad parity flags the command but does not stop it
                        if (!rx_parity_ok) begin
                            cmd_error <= 1'b1;
                        end
                        if (!is_config) begin
                            status_valid <= 1'b1;
                        end
                        if (last_word) begin
                            state <= S_DONE;
                        end
                    end
                end
                S_DONE: begin
                    state    <= S_IDLE;
                    cmd_done <= 1'b1;
                    cmd_busy <= 1'b0;
                end
                S_ERROR: begin
                    state     <= S_IDLE;
                    cmd_done  <= 1'b1;
                    cmd_busy  <= 1'b0;
                    cmd_error <= 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Payload registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            req      <= request;
            tx_frame <= {header, esdi_parity(header)};
        end else if (state == S_WAIT_ACK && ack_pulse && need_param) begin
            tx_frame <= {req.param, esdi_parity(req.param)};
        end
        if (state == S_RECEIVE && rx_done && !is_config) begin
            status_word <= rx_word;
        end
    end

    // Serializer finishes only inside a send
    a_done_within_req: assert property (
        @(posedge clk) disable iff (reset) tx_done |-> transfer_req
    );

endmodule

// File: source/esdi_geometry.sv
// Fixed six-word decode; alternate packing only when word 5 is all zero, no total recompute
`timescale 1ns/1ns

module esdi_geometry (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cfg_clear,
    input  logic                    cfg_store,
    input  logic                    cfg_finish,
    input  esdi_pkg::esdi_word_t    rx_word,
    output esdi_pkg::drive_geometry_t geometry,
    output logic                    config_valid
);

    import esdi_pkg::*;

    esdi_word_t      cfg_words [CONFIG_WORDS];
    logic [2:0]      cfg_idx;
    drive_geometry_t decoded;

    // Word index and valid flag
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_idx      <= '0;
            config_valid <= 1'b0;
        end else if (cfg_clear) begin
            cfg_idx      <= '0;
            config_valid <= 1'b0;
        end else begin
            if (cfg_store) begin
                cfg_idx <= cfg_idx + 3'd1;
            end
            if (cfg_finish) begin
                config_valid <= 1'b1;
            end
        end
    end

    // Word storage
    always_ff @(posedge clk) begin
        if (cfg_store) begin
            cfg_words[cfg_idx] <= rx_word;
        end
    end

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------
    always_comb begin
        decoded.total_sectors = {cfg_words[2], cfg_words[3]};
        if (cfg_words[5] == 16'd0) begin
            // Geometry packed into words 3 and 4
            decoded.cylinders         = {8'd0, cfg_words[3][15:8]};
            decoded.heads             = cfg_words[4][15:8];
            decoded.sectors_per_track = cfg_words[4][7:0];
        end else begin
            decoded.cylinders         = cfg_words[4];
            decoded.heads             = cfg_words[5][15:8];
            decoded.sectors_per_track = cfg_words[5][7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_finish) begin
            geometry <= decoded;
        end
    end

    // Response never longer than the configuration block
    a_no_store_overflow: assert property (
        @(posedge clk) disable iff (reset) cfg_store |-> cfg_idx < 3'(CONFIG_WORDS)
    );

endmodule

// File: source/esdi_line_inputs.sv
// Two-flop synchronizers only; ack_pulse lags the raw acknowledge rise by 3 cycles
`timescale 1ns/1ns

module esdi_line_inputs (
    input  logic clk,
    input  logic reset,
    input  logic transfer_ack,
    input  logic attention,
    input  logic status_data_in,
    output logic ack_pulse,
    output logic rx_line,
    output logic attention_pending
);

    // Synchronizer chains, bit 1 is the usable stage
    logic [1:0] ack_sync;
    logic [1:0] att_sync;
    logic [1:0] data_sync;

    // Previous synchronized levels for edge detection
    logic ack_prev;
    logic att_prev;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_sync          <= 2'b00;
            att_sync          <= 2'b00;
            data_sync         <= 2'b00;
            ack_prev          <= 1'b0;
            att_prev          <= 1'b0;
            ack_pulse         <= 1'b0;
            attention_pending <= 1'b0;
        end else begin
            ack_sync  <= {ack_sync[0], transfer_ack};
            att_sync  <= {att_sync[0], attention};
            data_sync <= {data_sync[0], status_data_in};
            ack_prev  <= ack_sync[1];
            att_prev  <= att_sync[1];
            // One cycle per acknowledge rise
            ack_pulse <= ack_sync[1] & ~ack_prev;
            // Sticky until reset
            if (att_sync[1] & ~att_prev) begin
                attention_pending <= 1'b1;
            end
        end
    end

    assign rx_line = data_sync[1];

endmodule

// File: source/esdi_pkg.sv
// Shared ESDI command channel types; parity is plain XOR of the 16 data bits, not odd parity
package esdi_pkg;

    // --------------------------------------------------
    // Word and frame widths
    // --------------------------------------------------

    // Data word on the serial lines
    typedef logic [15:0] esdi_word_t;

    // Serial frame, data word in [16:1] and parity in [0]
    typedef logic [16:0] esdi_frame_t;

    // Command opcode, low byte of the header
    typedef logic [7:0] esdi_opcode_t;

    // --------------------------------------------------
    // Opcodes
    // --------------------------------------------------
    localparam esdi_opcode_t OP_READ           = 8'h01;
    localparam esdi_opcode_t OP_WRITE          = 8'h02;
    localparam esdi_opcode_t OP_SEEK           = 8'h05;
    localparam esdi_opcode_t OP_PARK_HEADS     = 8'h06;
    localparam esdi_opcode_t OP_GET_DEV_STATUS = 8'h08;
    localparam esdi_opcode_t OP_GET_DEV_CONFIG = 8'h09;
    localparam esdi_opcode_t OP_GET_POS_INFO   = 8'h0A;

    // Words in a GET_DEV_CONFIG response
    localparam int CONFIG_WORDS = 6;

    // --------------------------------------------------
    // Structs
    // --------------------------------------------------

    // Command request from the host side
    typedef struct packed {
        esdi_opcode_t opcode;
        // Cylinder for SEEK, ignored otherwise
        esdi_word_t   param;
        // Drive select, lands in header bit 13
        logic         drive;
    } cmd_request_t;

    // Decoded drive geometry
    typedef struct packed {
        logic [15:0] cylinders;
        logic [7:0]  heads;
        logic [7:0]  sectors_per_track;
        logic [31:0] total_sectors;
    } drive_geometry_t;

    // --------------------------------------------------
    // Parity
    // --------------------------------------------------

    // XOR over all data bits
    function automatic logic esdi_parity(input esdi_word_t data);
        return ^data;
    endfunction

endpackage

// File: test/esdi_cmd_tb.sv
// Drive model assumes BIT_PERIOD 16, a 3-cycle ack path and at most six response words
`timescale 1ns/1ns

module esdi_cmd_tb;

    import esdi_pkg::*;

    localparam int BIT_PERIOD  = 16;
    localparam int ACK_TIMEOUT = 512;
    localparam int WAIT_LIMIT  = 4000;

    logic            clk;
    logic            reset;
    logic            cmd_enable;
    logic            cmd_start;
    cmd_request_t    request;
    logic            cmd_busy;
    logic            cmd_done;
    logic            cmd_error;
    esdi_word_t      status_word;
    logic            status_valid;
    drive_geometry_t geometry;
    logic            config_valid;
    logic            attention_pending;
    logic            cmd_data_out;
    logic            cmd_data_oe;
    logic            transfer_req;
    logic            status_data_in;
    logic            transfer_ack;
    logic            attention;

    integer      seed;
    int          status_count = 0;
    int          status_base;
    esdi_word_t  expected_status;
    esdi_word_t  resp_words[$];
    esdi_frame_t frame;
    esdi_word_t  cyl;
    logic        drv;

    esdi_cmd #(.BIT_PERIOD(BIT_PERIOD), .ACK_TIMEOUT(ACK_TIMEOUT)) uut (
        .clk(clk), .reset(reset), .cmd_enable(cmd_enable), .cmd_start(cmd_start),
        .request(request), .cmd_busy(cmd_busy), .cmd_done(cmd_done), .cmd_error(cmd_error),
        .status_word(status_word), .status_valid(status_valid), .geometry(geometry),
        .config_valid(config_valid), .attention_pending(attention_pending),
        .cmd_data_out(cmd_data_out), .cmd_data_oe(cmd_data_oe), .transfer_req(transfer_req),
        .status_data_in(status_data_in), .transfer_ack(transfer_ack), .attention(attention)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // Even XOR over the data bits, one bit at a time
    function automatic logic ref_parity(input esdi_word_t w);
        logic       p;
        esdi_word_t t;
        p = 1'b0;
        t = w;
        repeat (16) begin
            p = p ^ t[0];
            t = t >> 1;
        end
        return p;
    endfunction

    // Drive bit at 13, opcode in the low byte, rest zero
    function automatic esdi_frame_t ref_header(input esdi_opcode_t op, input logic d);
        esdi_word_t h;
        h = 16'h0000;
        h[13] = d;
        h[7:0] = op;
        return {h, ref_parity(h)};
    endfunction

    function automatic esdi_frame_t ref_param_frame(input esdi_word_t w);
        return {w, ref_parity(w)};
    endfunction

    // Normal layout, or words 3/4 when word 5 is zero
    function automatic drive_geometry_t ref_geometry();
        drive_geometry_t g;
        g.total_sectors = {resp_words[2], resp_words[3]};
        if (resp_words[5] == 16'h0000) begin
            g.cylinders         = {8'h00, resp_words[3][15:8]};
            g.heads             = resp_words[4][15:8];
            g.sectors_per_track = resp_words[4][7:0];
        end else begin
            g.cylinders         = resp_words[4];
            g.heads             = resp_words[5][15:8];
            g.sectors_per_track = resp_words[5][7:0];
        end
        return g;
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic frame_check(input string name, input esdi_frame_t exp, input esdi_frame_t act);
        if (exp !== act) begin
            abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic word_check(input string name, input esdi_word_t exp, input esdi_word_t act);
        if (exp !== act) begin
            abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic geometry_check(input string name, input drive_geometry_t exp,
                                  input drive_geometry_t act);
        if (exp !== act) begin
            abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic flag_check(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Status pulses are sampled at the rising edge that ends them
    always @(posedge clk) begin
        if (!reset && status_valid) begin
            status_count = status_count + 1;
            word_check("status word on pulse", expected_status, status_word);
        end
    end

    // --------------------------------------------------
    // Drive model and waits
    // --------------------------------------------------
    task automatic wait_req(input logic level);
        int n;
        n = 0;
        while (transfer_req !== level) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("Timeout waiting for transfer_req to change");
            end
        end
    endtask

    task automatic wait_cmd_done(input int limit);
        int n;
        n = 0;
        while (cmd_done !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                abort_run("Timeout waiting for cmd_done");
            end
        end
    endtask

    task automatic wait_attention();
        int n;
        n = 0;
        while (attention_pending !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > 20) begin
                abort_run("attention_pending never rose after attention");
            end
        end
    endtask

    task automatic issue_cmd(input esdi_opcode_t op, input esdi_word_t param, input logic d);
        @(negedge clk);
        request.opcode = op;
        request.param  = param;
        request.drive  = d;
        cmd_start      = 1'b1;
        @(negedge clk);
        cmd_start = 1'b0;
    endtask

    // Serializer starts one cycle after transfer_req, sample mid-bit
    task automatic capture_frame(output esdi_frame_t f);
        wait_req(1'b1);
        repeat (BIT_PERIOD / 2 + 1) @(negedge clk);
        repeat (17) begin
            f = {f[15:0], cmd_data_out};
            // Line driven and request up for the whole frame
            flag_check("send cmd_data_oe", 1'b1, cmd_data_oe);
            flag_check("send transfer_req", 1'b1, transfer_req);
            repeat (BIT_PERIOD) @(negedge clk);
        end
        wait_req(1'b0);
        flag_check("released cmd_data_oe", 1'b0, cmd_data_oe);
    endtask

    task automatic ack_frame();
        transfer_ack = 1'b1;
        repeat (3) @(negedge clk);
        transfer_ack = 1'b0;
    endtask

    // Ack rise and first response bit share one falling edge
    task automatic send_response(input logic flip);
        esdi_word_t  q[$];
        esdi_word_t  w;
        esdi_frame_t f;
        int          n;
        q = resp_words;
        n = 0;
        transfer_ack = 1'b1;
        while (q.size() > 0) begin
            w = q.pop_front();
            f = {w, ref_parity(w) ^ flip};
            repeat (17) begin
                status_data_in = f[16];
                f = f << 1;
                repeat (BIT_PERIOD) begin
                    @(negedge clk);
                    n++;
                    if (n == 3) begin
                        transfer_ack = 1'b0;
                    end
                end
            end
        end
        status_data_in = 1'b0;
    endtask

    // Header, one status word back
    task automatic status_command(input string name, input esdi_opcode_t op, input logic flip,
                                  input logic expect_error);
        esdi_frame_t f;
        logic        d;
        d = 1'($random(seed));
        resp_words.delete();
        resp_words.push_back(16'($random(seed)));
        expected_status = resp_words[0];
        status_base = status_count;
        issue_cmd(op, 16'h0000, d);
        flag_check({name, " busy"}, 1'b1, cmd_busy);
        capture_frame(f);
        frame_check({name, " header"}, ref_header(op, d), f);
        send_response(flip);
        wait_cmd_done(WAIT_LIMIT);
        flag_check({name, " error"}, expect_error, cmd_error);
        flag_check({name, " status pulse"}, 1'b1, status_count == status_base + 1);
        word_check({name, " status word"}, expected_status, status_word);
    endtask

    task automatic config_command(input string name, input logic zero_word5);
        esdi_frame_t f;
        resp_words.delete();
        repeat (CONFIG_WORDS) begin
            resp_words.push_back(16'($random(seed)));
        end
        if (zero_word5) begin
            resp_words[5] = 16'h0000;
        end else if (resp_words[5] == 16'h0000) begin
            resp_words[5] = 16'h0811;
        end
        status_base = status_count;
        issue_cmd(OP_GET_DEV_CONFIG, 16'h0000, 1'b1);
        capture_frame(f);
        frame_check({name, " header"}, ref_header(OP_GET_DEV_CONFIG, 1'b1), f);
        send_response(1'b0);
        wait_cmd_done(WAIT_LIMIT);
        flag_check({name, " error"}, 1'b0, cmd_error);
        flag_check({name, " config_valid"}, 1'b1, config_valid);
        flag_check({name, " no status"}, 1'b1, status_count == status_base);
        geometry_check({name, " geometry"}, ref_geometry(), geometry);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        seed            = 32'hcb4d;
        expected_status = 16'h0000;
        reset           = 1'b1;
        cmd_enable      = 1'b1;
        cmd_start       = 1'b0;
        request         = '0;
        status_data_in  = 1'b0;
        transfer_ack    = 1'b0;
        attention       = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        flag_check("reset busy", 1'b0, cmd_busy);
        flag_check("reset transfer_req", 1'b0, transfer_req);
        flag_check("reset cmd_data_oe", 1'b0, cmd_data_oe);
        flag_check("reset attention", 1'b0, attention_pending);
        flag_check("reset config_valid", 1'b0, config_valid);
        flag_check("reset cmd_error", 1'b0, cmd_error);

        // SEEK sends header then cylinder, each acked
        cyl = 16'($random(seed));
        drv = 1'($random(seed));
        resp_words.delete();
        resp_words.push_back(16'($random(seed)));
        expected_status = resp_words[0];
        status_base = status_count;
        issue_cmd(OP_SEEK, cyl, drv);
        capture_frame(frame);
        frame_check("seek header", ref_header(OP_SEEK, drv), frame);
        ack_frame();
        capture_frame(frame);
        frame_check("seek cylinder", ref_param_frame(cyl), frame);
        send_response(1'b0);
        wait_cmd_done(WAIT_LIMIT);
        flag_check("seek error", 1'b0, cmd_error);
        flag_check("seek status pulse", 1'b1, status_count == status_base + 1);

        status_command("get status", OP_GET_DEV_STATUS, 1'b0, 1'b0);
        // Flipped parity still completes, with error
        status_command("read bad parity", OP_READ, 1'b1, 1'b1);
        config_command("config normal", 1'b0);
        config_command("config alternate", 1'b1);

        // Withheld acknowledge ends in timeout
        status_base = status_count;
        issue_cmd(OP_PARK_HEADS, 16'h0000, 1'b0);
        capture_frame(frame);
        frame_check("park header", ref_header(OP_PARK_HEADS, 1'b0), frame);
        wait_cmd_done(ACK_TIMEOUT + 32);
        flag_check("park error", 1'b1, cmd_error);
        flag_check("park no status", 1'b1, status_count == status_base);
        // A new command drops the old configuration
        flag_check("park config cleared", 1'b0, config_valid);

        // Disabled start is dropped
        cmd_enable = 1'b0;
        issue_cmd(OP_READ, 16'h0000, 1'b0);
        flag_check("disabled busy", 1'b0, cmd_busy);
        repeat (40) begin
            @(negedge clk);
            flag_check("disabled busy", 1'b0, cmd_busy);
        end
        cmd_enable = 1'b1;

        // Attention is sticky across commands
        @(negedge clk);
        attention = 1'b1;
        wait_attention();
        attention = 1'b0;
        status_command("position after attention", OP_GET_POS_INFO, 1'b0, 1'b0);
        flag_check("attention held", 1'b1, attention_pending);

        $display("All tests passed");
        $finish;
    end

endmodule

// File: vlog.f
source/esdi_pkg.sv
source/esdi_line_inputs.sv
source/esdi_bit_tx.sv
source/esdi_bit_rx.sv
source/esdi_geometry.sv
source/esdi_cmd_seq.sv
source/esdi_cmd.sv
test/esdi_cmd_tb.sv
